// File: Makefile
# Verilator build and run of the carry resolution testbench

SIM := obj_dir/Vtb_carry_propagation
SOURCES := $(shell cat tb.f)

.PHONY: all run clean

all: run

$(SIM): tb.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_carry_propagation -f tb.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb.f
verilog/carry_pkg.sv
verilog/lane_resolver.sv
verilog/carry_state.sv
verilog/segment_packer.sv
verilog/carry_propagation.sv
testbench/tb_clock.sv
testbench/tb_carry_propagation.sv

// File: testbench/tb_carry_propagation.sv
// --------------------
// Testbench for the carry resolution stage with a directed table and a
// random stream checked against a reference model, plus a watchdog
// --------------------
module tb_carry_propagation;
    timeunit 1ns;
    timeprecision 1ps;

    import carry_pkg::*;

    localparam int NUM_ROWS = 19;
    localparam int RANDOM_CYCLES = 300;
    localparam int unsigned SEED = 32'ha8ceb65e;

    // Expected bytes and counts are packed with slot 0 in the top byte
    typedef struct {
        logic        start;
        logic        fin;
        lane_count_t lanes;
        lane_word_t  w1;
        lane_word_t  w2;
        logic [31:0] bytes;
        logic [31:0] lens;
        logic        valid;
        logic        last_flag;
    } row_t;

    logic        clk;
    logic        reset;
    logic        start;
    logic        is_final;
    lane_count_t lane_count;
    lane_word_t  word_1;
    lane_word_t  word_2;
    byte_t       seg_byte_0;
    byte_t       seg_byte_1;
    byte_t       seg_byte_2;
    byte_t       seg_byte_3;
    run_len_t    seg_len_0;
    run_len_t    seg_len_1;
    run_len_t    seg_len_2;
    run_len_t    seg_len_3;
    logic        seg_valid;
    logic        last;

    byte_t       seg_byte [4];
    run_len_t    seg_len [4];
    row_t        stim_rows [NUM_ROWS];
    int          row_fill;
    byte_t       exp_byte [4];
    run_len_t    exp_len [4];
    int          exp_count;
    logic        exp_valid;
    logic        exp_last;
    byte_t       model_pend;
    run_len_t    model_run;
    int          table_errors;
    int          random_errors;
    logic        in_random;

    tb_clock u_clock (
        .clk (clk)
    );

    carry_propagation u_dut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .is_final   (is_final),
        .lane_count (lane_count),
        .word_1     (word_1),
        .word_2     (word_2),
        .seg_byte_0 (seg_byte_0),
        .seg_byte_1 (seg_byte_1),
        .seg_byte_2 (seg_byte_2),
        .seg_byte_3 (seg_byte_3),
        .seg_len_0  (seg_len_0),
        .seg_len_1  (seg_len_1),
        .seg_len_2  (seg_len_2),
        .seg_len_3  (seg_len_3),
        .seg_valid  (seg_valid),
        .last       (last)
    );

    assign seg_byte[0] = seg_byte_0;
    assign seg_byte[1] = seg_byte_1;
    assign seg_byte[2] = seg_byte_2;
    assign seg_byte[3] = seg_byte_3;
    assign seg_len[0] = seg_len_0;
    assign seg_len[1] = seg_len_1;
    assign seg_len[2] = seg_len_2;
    assign seg_len[3] = seg_len_3;

    // --------------------
    // Stimulus helpers
    // --------------------
    task automatic add_row(input logic st, input logic fn, input lane_count_t lc,
                           input lane_word_t w1, input lane_word_t w2,
                           input logic [31:0] bytes, input logic [31:0] lens,
                           input logic v, input logic lst);
        stim_rows[row_fill] = '{st, fn, lc, w1, w2, bytes, lens, v, lst};
        row_fill++;
    endtask

    task automatic apply_inputs(input logic st, input logic fn, input lane_count_t lc,
                                input lane_word_t w1, input lane_word_t w2);
        start = st;
        is_final = fn;
        lane_count = lc;
        word_1 = w1;
        word_2 = w2;
    endtask

    function automatic lane_word_t random_word();
        int unsigned pick;
        pick = $urandom_range(3);
        // Half of the words extend a run and a quarter carry into the pending byte
        if (pick < 2) begin
            return 16'h00FF;
        end else if (pick == 2) begin
            return {7'($urandom), 1'b1, 8'($urandom)};
        end
        return 16'($urandom);
    endfunction

    // --------------------
    // Reference model
    // --------------------
    task automatic emit(input byte_t b, input run_len_t n);
        if (n != 0 && exp_count < 4) begin
            exp_byte[exp_count] = b;
            exp_len[exp_count] = n;
            exp_count++;
        end
    endtask

    task automatic resolve_word(input code_word_t w);
        logic carry;
        carry = w[8];
        if (w == 9'h0FF) begin
            model_run = model_run + 8'd1;
        end else begin
            emit(model_pend + {7'd0, carry}, 8'd1);
            emit(8'hFF + {7'd0, carry}, model_run);
            model_pend = w[7:0];
            model_run = 8'd0;
        end
    endtask

    task automatic model_step(input logic st, input logic fn, input lane_count_t lc,
                              input lane_word_t w1, input lane_word_t w2);
        exp_count = 0;
        for (int k = 0; k < 4; k++) begin
            exp_byte[k] = 8'd0;
            exp_len[k] = 8'd0;
        end
        if (st) begin
            model_pend = 8'd0;
            model_run = 8'd0;
        end else begin
            if (lc >= 1) begin
                resolve_word(w1[8:0]);
            end
            if (lc == 2) begin
                resolve_word(w2[8:0]);
            end
            if (fn) begin
                // Flush writes out whatever is held without any carry
                emit(model_pend, 8'd1);
                emit(8'hFF, model_run);
                model_pend = 8'd0;
                model_run = 8'd0;
            end
        end
        exp_valid = (exp_count != 0);
        exp_last = fn;
    endtask

    // --------------------
    // Checks
    // --------------------
    task automatic note_error();
        if (in_random) begin
            random_errors++;
        end else begin
            table_errors++;
        end
    endtask

    task automatic check_outputs(input int cycle);
        for (int k = 0; k < 4; k++) begin
            assert (seg_len[k] == exp_len[k]) else begin
                $display("ERR %0t: cycle %0d slot %0d count %0d, expected %0d",
                         $time, cycle, k, seg_len[k], exp_len[k]);
                note_error();
            end
            // A byte only means something in a slot that is in use
            if (exp_len[k] != 0) begin
                assert (seg_byte[k] == exp_byte[k]) else begin
                    $display("ERR %0t: cycle %0d slot %0d byte %h, expected %h",
                             $time, cycle, k, seg_byte[k], exp_byte[k]);
                    note_error();
                end
            end
        end
        assert (seg_valid == exp_valid) else begin
            $display("ERR %0t: cycle %0d seg_valid %b, expected %b",
                     $time, cycle, seg_valid, exp_valid);
            note_error();
        end
        assert (last == exp_last) else begin
            $display("ERR %0t: cycle %0d last %b, expected %b", $time, cycle, last, exp_last);
            note_error();
        end
    endtask

    task automatic fill_table();
        row_fill = 0;
        add_row(1, 0, 0, 16'h0000, 16'h0000, 32'h0000_0000, 32'h0000_0000, 0, 0);
        add_row(0, 0, 1, 16'h0012, 16'h0000, 32'h0000_0000, 32'h0100_0000, 1, 0);
        // Three run words, then a carry settles them
        add_row(0, 0, 1, 16'h00FF, 16'h0000, 32'h0000_0000, 32'h0000_0000, 0, 0);
        add_row(0, 0, 2, 16'h00FF, 16'h00FF, 32'h0000_0000, 32'h0000_0000, 0, 0);
        add_row(0, 0, 1, 16'h0105, 16'h0000, 32'h1300_0000, 32'h0103_0000, 1, 0);
        // Both lanes resolve and lane 2 has no fill
        add_row(0, 0, 1, 16'h00FF, 16'h0000, 32'h0000_0000, 32'h0000_0000, 0, 0);
        add_row(0, 0, 2, 16'h01A0, 16'h0133, 32'h0600_A100, 32'h0101_0100, 1, 0);
        // Final with a run word in lane 2 fills all four slots
        add_row(0, 0, 1, 16'h00FF, 16'h0000, 32'h0000_0000, 32'h0000_0000, 0, 0);
        add_row(0, 1, 2, 16'h007E, 16'h00FF, 32'h33FF_7EFF, 32'h0101_0101, 1, 1);
        add_row(0, 0, 1, 16'h0020, 16'h0000, 32'h0000_0000, 32'h0100_0000, 1, 0);
        // Start discards its lanes and the held run
        add_row(0, 0, 1, 16'h00FF, 16'h0000, 32'h0000_0000, 32'h0000_0000, 0, 0);
        add_row(1, 0, 2, 16'h0140, 16'h0155, 32'h0000_0000, 32'h0000_0000, 0, 0);
        add_row(0, 0, 1, 16'h0101, 16'h0000, 32'h0100_0000, 32'h0100_0000, 1, 0);
        add_row(0, 1, 0, 16'h0000, 16'h0000, 32'h0100_0000, 32'h0100_0000, 1, 1);
        add_row(0, 0, 1, 16'h0011, 16'h01FF, 32'h0000_0000, 32'h0100_0000, 1, 0);
        add_row(1, 1, 0, 16'h0000, 16'h0000, 32'h0000_0000, 32'h0000_0000, 0, 1);
        add_row(0, 0, 0, 16'h0000, 16'h0000, 32'h0000_0000, 32'h0000_0000, 0, 0);
        // Upper lane bits are ignored
        add_row(0, 0, 1, 16'hA0FF, 16'h0000, 32'h0000_0000, 32'h0000_0000, 0, 0);
        add_row(0, 0, 1, 16'h3E42, 16'h0000, 32'h00FF_0000, 32'h0101_0000, 1, 0);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin : main
        logic        rnd_final;
        lane_count_t rnd_lanes;
        lane_word_t  rnd_w1;
        lane_word_t  rnd_w2;

        void'($urandom(SEED));
        table_errors = 0;
        random_errors = 0;
        in_random = 1'b0;
        model_pend = 8'd0;
        model_run = 8'd0;
        reset = 1'b1;
        apply_inputs(1'b0, 1'b0, 2'd0, 16'h0000, 16'h0000);
        fill_table();

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_inputs(stim_rows[i].start, stim_rows[i].fin, stim_rows[i].lanes,
                         stim_rows[i].w1, stim_rows[i].w2);
            for (int k = 0; k < 4; k++) begin
                exp_byte[k] = stim_rows[i].bytes[31 - 8*k -: 8];
                exp_len[k] = stim_rows[i].lens[31 - 8*k -: 8];
            end
            exp_valid = stim_rows[i].valid;
            exp_last = stim_rows[i].last_flag;
            @(negedge clk);
            check_outputs(i);
        end

        // The random stream opens with start so that model and DUT agree
        in_random = 1'b1;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rnd_final = ($urandom_range(9) == 0);
            rnd_lanes = lane_count_t'($urandom_range(2));
            rnd_w1 = random_word();
            rnd_w2 = random_word();
            apply_inputs(n == 0, rnd_final, rnd_lanes, rnd_w1, rnd_w2);
            model_step(n == 0, rnd_final, rnd_lanes, rnd_w1, rnd_w2);
            @(negedge clk);
            check_outputs(NUM_ROWS + n);
        end

        $display("Errors: %0d in table rows, %0d in random cycles",
                 table_errors, random_errors);
        if (table_errors + random_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((NUM_ROWS + RANDOM_CYCLES + 20) * 20);
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
// --------------------
// Free-running testbench clock, 10 ns period
// --------------------
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// File: verilog/carry_pkg.sv
// --------------------
// Widths, constants and vector types shared by the carry resolution stage
// --------------------
package carry_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int BYTE_WIDTH = 8;

    // A code word is one carry bit above one output byte
    localparam int CODE_WIDTH = BYTE_WIDTH + 1;

    // Input lanes are wider than a code word, only the low bits count
    localparam int LANE_WIDTH = 16;

    localparam int RUN_WIDTH = 8;
    localparam int LANE_COUNT_WIDTH = 2;

    // --------------------
    // Output slots
    // --------------------
    // Two lanes and the flush logic each offer a head and a fill segment
    localparam int NUM_CANDIDATES = 6;
    localparam int NUM_SEGMENTS = 4;

    // --------------------
    // Vector types
    // --------------------
    typedef logic [BYTE_WIDTH-1:0]       byte_t;
    typedef logic [CODE_WIDTH-1:0]       code_word_t;
    typedef logic [LANE_WIDTH-1:0]       lane_word_t;
    typedef logic [RUN_WIDTH-1:0]        run_len_t;
    typedef logic [LANE_COUNT_WIDTH-1:0] lane_count_t;

    // --------------------
    // Code constants
    // --------------------
    // Carry clear with byte 0xFF, the only word that extends a run
    localparam code_word_t RUN_WORD = 9'h0FF;

    // Byte emitted for each member of a run before the carry is added
    localparam byte_t FILL_BYTE = 8'hFF;

endpackage

// File: verilog/carry_propagation.sv
// --------------------
// Carry resolution stage: two chained lane resolvers, state and packer
// --------------------
module carry_propagation (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    // Final marker of the stream
    input  logic                   is_final,
    input  carry_pkg::lane_count_t lane_count,
    input  carry_pkg::lane_word_t  word_1,
    input  carry_pkg::lane_word_t  word_2,
    output carry_pkg::byte_t       seg_byte_0,
    output carry_pkg::byte_t       seg_byte_1,
    output carry_pkg::byte_t       seg_byte_2,
    output carry_pkg::byte_t       seg_byte_3,
    output carry_pkg::run_len_t    seg_len_0,
    output carry_pkg::run_len_t    seg_len_1,
    output carry_pkg::run_len_t    seg_len_2,
    output carry_pkg::run_len_t    seg_len_3,
    output logic                   seg_valid,
    output logic                   last
);
    import carry_pkg::*;

    logic       lane_valid_1;
    logic       lane_valid_2;
    code_word_t code_1;
    code_word_t code_2;

    // State as held, after lane 1, and after lane 2
    byte_t      pending;
    run_len_t   run;
    byte_t      pending_mid;
    run_len_t   run_mid;
    byte_t      pending_next;
    run_len_t   run_next;

    byte_t      head_byte_1;
    run_len_t   head_len_1;
    byte_t      fill_byte_1;
    run_len_t   fill_len_1;
    byte_t      head_byte_2;
    run_len_t   head_len_2;
    byte_t      fill_byte_2;
    run_len_t   fill_len_2;
    byte_t      flush_head_byte;
    run_len_t   flush_head_len;
    byte_t      flush_fill_byte;
    run_len_t   flush_fill_len;

    assign lane_valid_1 = (lane_count != 2'd0);
    assign lane_valid_2 = (lane_count == 2'd2);
    assign code_1 = word_1[CODE_WIDTH-1:0];
    assign code_2 = word_2[CODE_WIDTH-1:0];

    lane_resolver u_lane_1 (
        .lane_valid  (lane_valid_1),
        .word        (code_1),
        .pending_in  (pending),
        .run_in      (run),
        .pending_out (pending_mid),
        .run_out     (run_mid),
        .head_byte   (head_byte_1),
        .head_len    (head_len_1),
        .fill_byte   (fill_byte_1),
        .fill_len    (fill_len_1)
    );

    lane_resolver u_lane_2 (
        .lane_valid  (lane_valid_2),
        .word        (code_2),
        .pending_in  (pending_mid),
        .run_in      (run_mid),
        .pending_out (pending_next),
        .run_out     (run_next),
        .head_byte   (head_byte_2),
        .head_len    (head_len_2),
        .fill_byte   (fill_byte_2),
        .fill_len    (fill_len_2)
    );

    carry_state u_state (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .is_final        (is_final),
        .pending_next    (pending_next),
        .run_next        (run_next),
        .pending         (pending),
        .run             (run),
        .flush_head_byte (flush_head_byte),
        .flush_fill_byte (flush_fill_byte),
        .flush_head_len  (flush_head_len),
        .flush_fill_len  (flush_fill_len)
    );

    segment_packer u_packer (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .is_final    (is_final),
        .cand_byte_0 (head_byte_1),
        .cand_byte_1 (fill_byte_1),
        .cand_byte_2 (head_byte_2),
        .cand_byte_3 (fill_byte_2),
        .cand_byte_4 (flush_head_byte),
        .cand_byte_5 (flush_fill_byte),
        .cand_len_0  (head_len_1),
        .cand_len_1  (fill_len_1),
        .cand_len_2  (head_len_2),
        .cand_len_3  (fill_len_2),
        .cand_len_4  (flush_head_len),
        .cand_len_5  (flush_fill_len),
        .seg_byte_0  (seg_byte_0),
        .seg_byte_1  (seg_byte_1),
        .seg_byte_2  (seg_byte_2),
        .seg_byte_3  (seg_byte_3),
        .seg_len_0   (seg_len_0),
        .seg_len_1   (seg_len_1),
        .seg_len_2   (seg_len_2),
        .seg_len_3   (seg_len_3),
        .seg_valid   (seg_valid),
        .last        (last)
    );

endmodule

// File: verilog/carry_state.sv
// --------------------
// Pending byte and run registers, start and final handling, flush segments
// --------------------
module carry_state (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    // Final marker of the stream
    input  logic                is_final,
    input  carry_pkg::byte_t    pending_next,
    input  carry_pkg::run_len_t run_next,
    output carry_pkg::byte_t    pending,
    output carry_pkg::run_len_t run,
    output carry_pkg::byte_t    flush_head_byte,
    output carry_pkg::byte_t    flush_fill_byte,
    output carry_pkg::run_len_t flush_head_len,
    output carry_pkg::run_len_t flush_fill_len
);
    import carry_pkg::*;

    logic flush_en;

    // Start wins over final, its lanes are discarded downstream anyway
    assign flush_en = is_final && !start;

    // --------------------
    // State registers
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            run <= '0;
        end else if (start || is_final) begin
            // Both markers leave the stage with nothing held
            pending <= '0;
            run <= '0;
        end else begin
            pending <= pending_next;
            run <= run_next;
        end
    end

    // --------------------
    // Flush segments
    // --------------------
    // On final the state left after both lanes is written out as is.
    // No later word can carry into it, so no carry is added here
    assign flush_head_byte = pending_next;
    assign flush_head_len = flush_en ? run_len_t'(1) : '0;

    assign flush_fill_byte = FILL_BYTE;
    assign flush_fill_len = flush_en ? run_next : '0;

endmodule

// File: verilog/lane_resolver.sv
// --------------------
// One code word applied to the pending byte and the 0xFF run
// --------------------
module lane_resolver (
    input  logic                  lane_valid,
    input  carry_pkg::code_word_t word,
    input  carry_pkg::byte_t      pending_in,
    input  carry_pkg::run_len_t   run_in,
    output carry_pkg::byte_t      pending_out,
    output carry_pkg::run_len_t   run_out,
    output carry_pkg::byte_t      head_byte,
    output carry_pkg::run_len_t   head_len,
    output carry_pkg::byte_t      fill_byte,
    output carry_pkg::run_len_t   fill_len
);
    import carry_pkg::*;

    logic  carry;
    logic  is_run;
    logic  resolve;
    byte_t carry_byte;

    assign carry = word[CODE_WIDTH-1];
    assign is_run = (word == RUN_WORD);

    // Any valid word other than the run word settles the bytes held so far
    assign resolve = lane_valid && !is_run;

    assign carry_byte = {{(BYTE_WIDTH-1){1'b0}}, carry};

    // --------------------
    // Segments
    // --------------------
    // The pending byte absorbs the carry
    assign head_byte = pending_in + carry_byte;
    assign head_len = resolve ? run_len_t'(1) : '0;

    // With the carry set each 0xFF wraps to 0x00
    assign fill_byte = FILL_BYTE + carry_byte;
    assign fill_len = resolve ? run_in : '0;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        pending_out = pending_in;
        run_out = run_in;
        if (lane_valid && is_run) begin
            // Counter wraps past 255, longer runs are not supported
            run_out = run_in + run_len_t'(1);
        end else if (resolve) begin
            pending_out = word[BYTE_WIDTH-1:0];
            run_out = '0;
        end
    end

endmodule

// File: verilog/segment_packer.sv
// --------------------
// Compaction of six candidate segments into four registered output slots
// --------------------
module segment_packer (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                is_final,
    input  carry_pkg::byte_t    cand_byte_0,
    input  carry_pkg::byte_t    cand_byte_1,
    input  carry_pkg::byte_t    cand_byte_2,
    input  carry_pkg::byte_t    cand_byte_3,
    input  carry_pkg::byte_t    cand_byte_4,
    input  carry_pkg::byte_t    cand_byte_5,
    input  carry_pkg::run_len_t cand_len_0,
    input  carry_pkg::run_len_t cand_len_1,
    input  carry_pkg::run_len_t cand_len_2,
    input  carry_pkg::run_len_t cand_len_3,
    input  carry_pkg::run_len_t cand_len_4,
    input  carry_pkg::run_len_t cand_len_5,
    output carry_pkg::byte_t    seg_byte_0,
    output carry_pkg::byte_t    seg_byte_1,
    output carry_pkg::byte_t    seg_byte_2,
    output carry_pkg::byte_t    seg_byte_3,
    output carry_pkg::run_len_t seg_len_0,
    output carry_pkg::run_len_t seg_len_1,
    output carry_pkg::run_len_t seg_len_2,
    output carry_pkg::run_len_t seg_len_3,
    output logic                seg_valid,
    output logic                last
);
    import carry_pkg::*;

    byte_t    cand_byte [NUM_CANDIDATES];
    run_len_t cand_len [NUM_CANDIDATES];
    byte_t    pack_byte [NUM_SEGMENTS];
    run_len_t pack_len [NUM_SEGMENTS];
    byte_t    seg_byte_q [NUM_SEGMENTS];
    run_len_t seg_len_q [NUM_SEGMENTS];

    // Candidates in stream order: lane 1, lane 2, then flush
    assign cand_byte[0] = cand_byte_0;
    assign cand_byte[1] = cand_byte_1;
    assign cand_byte[2] = cand_byte_2;
    assign cand_byte[3] = cand_byte_3;
    assign cand_byte[4] = cand_byte_4;
    assign cand_byte[5] = cand_byte_5;
    assign cand_len[0] = cand_len_0;
    assign cand_len[1] = cand_len_1;
    assign cand_len[2] = cand_len_2;
    assign cand_len[3] = cand_len_3;
    assign cand_len[4] = cand_len_4;
    assign cand_len[5] = cand_len_5;

    // --------------------
    // Compaction
    // --------------------
    // At most four candidates are nonempty in one cycle, since a resolve
    // clears the run that the next stage would otherwise fill out
    always_comb begin : compact
        logic [2:0] slot;
        slot = '0;
        for (int k = 0; k < NUM_SEGMENTS; k++) begin
            pack_byte[k] = '0;
            pack_len[k] = '0;
        end
        for (int i = 0; i < NUM_CANDIDATES; i++) begin
            if ((cand_len[i] != '0) && (slot < NUM_SEGMENTS)) begin
                pack_byte[slot[1:0]] = cand_byte[i];
                pack_len[slot[1:0]] = cand_len[i];
                slot = slot + 3'd1;
            end
        end
    end

    // --------------------
    // Output registers
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < NUM_SEGMENTS; k++) begin
                seg_len_q[k] <= '0;
            end
            seg_valid <= 1'b0;
            last <= 1'b0;
        end else begin
            // A start cycle emits nothing
            for (int k = 0; k < NUM_SEGMENTS; k++) begin
                seg_len_q[k] <= start ? '0 : pack_len[k];
            end
            // Slots fill from 0, so slot 0 tells whether any is used
            seg_valid <= !start && (pack_len[0] != '0);
            last <= is_final;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_SEGMENTS; k++) begin
            seg_byte_q[k] <= pack_byte[k];
        end
    end

    assign seg_byte_0 = seg_byte_q[0];
    assign seg_byte_1 = seg_byte_q[1];
    assign seg_byte_2 = seg_byte_q[2];
    assign seg_byte_3 = seg_byte_q[3];
    assign seg_len_0 = seg_len_q[0];
    assign seg_len_1 = seg_len_q[1];
    assign seg_len_2 = seg_len_q[2];
    assign seg_len_3 = seg_len_q[3];

endmodule
